//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module tb_top -f tb.f
	./obj_dir/Vtb_top +verilator+error+limit+100 | tee /dev/stderr | grep -q "^TEST RESULT: PASS$$"

lint:
	verilator --lint-only -Wall --timing --assert --top-module tb_top -f tb.f

clean:
	rm -rf obj_dir

//--- hdl/commit_top.sv
`timescale 1ns/100ps

module commit_top
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_valid,
  input  logic                  i_wen,
  input  logic                  i_brch,
  input  logic                  i_jal,
  input  logic                  i_jalr,
  input  logic                  i_csr,
  input  logic                  i_ecall,
  input  logic                  i_mret,
  input  logic [REG_ADDR_W-1:0] i_rd,
  input  logic [REG_ADDR_W-1:0] i_rs1_idx,
  input  logic [CSR_ADDR_W-1:0] i_csr_addr,
  input  logic [XLEN-1:0]       i_imm,
  input  logic [XLEN-1:0]       i_res,
  output logic                  o_commit_valid,
  output logic [XLEN-1:0]       o_commit_pc,
  output logic [XLEN-1:0]       o_commit_next_pc,
  output logic [REG_ADDR_W-1:0] o_commit_rd,
  output logic                  o_commit_wen,
  output logic [XLEN-1:0]       o_commit_rd_wdata
);

  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       mtvec;
  logic [XLEN-1:0]       mepc;
  logic [XLEN-1:0]       csr_rdata;
  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       pc_next;
  logic [XLEN-1:0]       rd_wdata;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic                  rd_wen;
  logic                  csr_wen;
  logic                  trap;

  wbu wbu_i (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_wen       (i_wen),
    .i_brch      (i_brch),
    .i_jal       (i_jal),
    .i_jalr      (i_jalr),
    .i_csr       (i_csr),
    .i_ecall     (i_ecall),
    .i_mret      (i_mret),
    .i_rd        (i_rd),
    .i_imm       (i_imm),
    .i_res       (i_res),
    .i_rs1       (rs1_data),
    .i_mtvec     (mtvec),
    .i_mepc      (mepc),
    .i_csr_rdata (csr_rdata),
    .o_pc        (pc),
    .o_pc_next   (pc_next),
    .o_rd_wdata  (rd_wdata),
    .o_rd_addr   (rd_addr),
    .o_rd_wen    (rd_wen),
    .o_csr_wen   (csr_wen),
    .o_trap      (trap)
  );

  gpr_file gpr_file_i (
    .clk     (clk),
    .i_reset (i_reset),
    .i_wen   (rd_wen),
    .i_waddr (rd_addr),
    .i_raddr (i_rs1_idx),
    .i_wdata (rd_wdata),
    .o_rdata (rs1_data)
  );

  // alu result carries the new csr value
  csr_file csr_file_i (
    .clk     (clk),
    .i_reset (i_reset),
    .i_wen   (csr_wen),
    .i_trap  (trap),
    .i_addr  (i_csr_addr),
    .i_wdata (i_res),
    .i_pc    (pc),
    .o_rdata (csr_rdata),
    .o_mtvec (mtvec),
    .o_mepc  (mepc)
  );

  // commit trace, one cycle behind the strobe
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_commit_valid <= 1'b0;
      o_commit_wen   <= 1'b0;
    end else begin
      o_commit_valid <= i_valid;
      o_commit_wen   <= rd_wen;
    end
  end

  always_ff @(posedge clk) begin
    o_commit_pc       <= pc;
    o_commit_next_pc  <= pc_next;
    o_commit_rd       <= rd_addr;
    o_commit_rd_wdata <= rd_wdata;
  end

endmodule

//--- hdl/core_pkg.sv
package core_pkg;

  // architectural widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;

  // first fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

  // pc step for a sequential instruction
  localparam logic [XLEN-1:0] INSN_BYTES = 32'd4;

  // machine mode csr addresses
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC  = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC   = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE = 12'h342;

  // environment call from m-mode
  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

endpackage

//--- hdl/csr_file.sv
`timescale 1ns/100ps

module csr_file
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_wen,
  input  logic                  i_trap,
  input  logic [CSR_ADDR_W-1:0] i_addr,
  input  logic [XLEN-1:0]       i_wdata,
  input  logic [XLEN-1:0]       i_pc,
  output logic [XLEN-1:0]       o_rdata,
  output logic [XLEN-1:0]       o_mtvec,
  output logic [XLEN-1:0]       o_mepc
);

  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  // read mux, unknown addresses read as zero
  always_comb begin
    case (i_addr)
      CSR_MTVEC:  o_rdata = mtvec;
      CSR_MEPC:   o_rdata = mepc;
      CSR_MCAUSE: o_rdata = mcause;
      default:    o_rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      mtvec <= '0;
    end else if (i_wen && (i_addr == CSR_MTVEC)) begin
      mtvec <= i_wdata;
    end
  end

  // trap capture overrides a software write in the same cycle
  always_ff @(posedge clk) begin
    if (i_reset) begin
      mepc   <= '0;
      mcause <= '0;
    end else if (i_trap) begin
      mepc   <= i_pc;
      mcause <= CAUSE_ECALL_M;
    end else if (i_wen) begin
      if (i_addr == CSR_MEPC) begin
        mepc <= i_wdata;
      end
      if (i_addr == CSR_MCAUSE) begin
        mcause <= i_wdata;
      end
    end
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

endmodule

//--- hdl/gpr_file.sv
`timescale 1ns/100ps

module gpr_file
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_wen,
  input  logic [REG_ADDR_W-1:0] i_waddr,
  input  logic [REG_ADDR_W-1:0] i_raddr,
  input  logic [XLEN-1:0]       i_wdata,
  output logic [XLEN-1:0]       o_rdata
);

  localparam int NUM_REGS = 1 << REG_ADDR_W;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // combinational read, x0 reads as zero
  assign o_rdata = (i_raddr == '0) ? '0 : regs[i_raddr];

endmodule

//--- hdl/wbu.sv
`timescale 1ns/100ps

module wbu
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_valid,
  input  logic                  i_wen,
  input  logic                  i_brch,
  input  logic                  i_jal,
  input  logic                  i_jalr,
  input  logic                  i_csr,
  input  logic                  i_ecall,
  input  logic                  i_mret,
  input  logic [REG_ADDR_W-1:0] i_rd,
  input  logic [XLEN-1:0]       i_imm,
  input  logic [XLEN-1:0]       i_res,
  input  logic [XLEN-1:0]       i_rs1,
  // trap vector and return address from the csr file
  input  logic [XLEN-1:0]       i_mtvec,
  input  logic [XLEN-1:0]       i_mepc,
  input  logic [XLEN-1:0]       i_csr_rdata,
  output logic [XLEN-1:0]       o_pc,
  output logic [XLEN-1:0]       o_pc_next,
  output logic [XLEN-1:0]       o_rd_wdata,
  output logic [REG_ADDR_W-1:0] o_rd_addr,
  output logic                  o_rd_wen,
  output logic                  o_csr_wen,
  output logic                  o_trap
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_seq;
  logic [XLEN-1:0] pc_rel;

  assign pc_seq = pc + INSN_BYTES;
  assign pc_rel = pc + i_imm;

  // next pc, jumps win over branch, then trap and return
  always_comb begin
    if (i_jal) begin
      o_pc_next = pc_rel;
    end else if (i_jalr) begin
      o_pc_next = i_rs1 + i_imm;
    end else if (i_brch && i_res[0]) begin
      o_pc_next = pc_rel;
    end else if (i_ecall) begin
      o_pc_next = i_mtvec;
    end else if (i_mret) begin
      o_pc_next = i_mepc;
    end else begin
      o_pc_next = pc_seq;
    end
  end

  // link address for jumps, old csr value for csr ops
  always_comb begin
    if (i_jal || i_jalr) begin
      o_rd_wdata = pc_seq;
    end else if (i_csr) begin
      o_rd_wdata = i_csr_rdata;
    end else begin
      o_rd_wdata = i_res;
    end
  end

  assign o_rd_addr = i_rd;

  // write strobes only live in the commit cycle
  assign o_rd_wen  = i_valid & i_wen;
  assign o_csr_wen = i_valid & i_csr;
  assign o_trap    = i_valid & i_ecall;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      pc <= RESET_PC;
    end else if (i_valid) begin
      pc <= o_pc_next;
    end
  end

  assign o_pc = pc;

endmodule

//--- tb.f
hdl/core_pkg.sv
hdl/wbu.sv
hdl/gpr_file.sv
hdl/csr_file.sv
hdl/commit_top.sv
testbench/commit_chk.sv
testbench/commit_checker.sv
testbench/tb_top.sv

//--- testbench/commit_checker.sv
`timescale 1ns/100ps

module commit_checker
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_commit_valid,
  input  logic [XLEN-1:0]       i_commit_pc,
  input  logic [XLEN-1:0]       i_commit_next_pc,
  input  logic [REG_ADDR_W-1:0] i_commit_rd,
  input  logic                  i_commit_wen,
  input  logic [XLEN-1:0]       i_commit_rd_wdata,
  output int                    o_errors,
  output int                    o_checked
);

  logic [127:0]          names [$];
  logic                  exp_wen [$];
  logic [REG_ADDR_W-1:0] exp_rd [$];
  logic [XLEN-1:0]       exp_next [$];
  logic [XLEN-1:0]       exp_rdata [$];
  // each commit starts where the previous one pointed
  logic [XLEN-1:0]       exp_pc = RESET_PC;
  int                    errors = 0;
  int                    idx = 0;

  assign o_errors  = errors;
  assign o_checked = idx;

  // packed name back to text, leading nulls dropped
  function automatic string name_of(logic [127:0] raw);
    string s = "";
    for (int i = 0; i < 16; i++) begin
      if (raw[127:120] != 8'h00) begin
        s = $sformatf("%s%c", s, raw[127:120]);
      end
      raw = raw << 8;
    end
    return s;
  endfunction

  task automatic compare(string test, string field, logic [XLEN-1:0] exp,
                         logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s %s expected %h actual %h", test, field, exp, act);
      errors++;
    end
  endtask

  initial begin
    int           fd;
    string        line;
    logic [127:0] name;
    logic [31:0]  v [14];
    fd = $fopen("testbench/commit_tests.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                    v[10], v[11], v[12], v[13]) == 15) begin
          names.push_back(name);
          exp_wen.push_back(v[0][0]);
          exp_rd.push_back(v[7][REG_ADDR_W-1:0]);
          exp_next.push_back(v[12]);
          exp_rdata.push_back(v[13]);
        end
      end
      $fclose(fd);
    end
  end

  // trace registers change on the rising edge
  always @(negedge clk) begin
    string test;
    if (!i_reset && i_commit_valid) begin
      if (idx >= names.size()) begin
        $display("commit at pc %h arrived with no expected line left", i_commit_pc);
        errors++;
      end else begin
        test = name_of(names[idx]);
        compare(test, "pc", exp_pc, i_commit_pc);
        compare(test, "next_pc", exp_next[idx], i_commit_next_pc);
        compare(test, "wen", XLEN'(exp_wen[idx]), XLEN'(i_commit_wen));
        if (i_commit_wen) begin
          compare(test, "rd", XLEN'(exp_rd[idx]), XLEN'(i_commit_rd));
          compare(test, $sformatf("x%0d", i_commit_rd), exp_rdata[idx], i_commit_rd_wdata);
        end
        exp_pc = exp_next[idx];
        idx++;
      end
    end
  end

endmodule

//--- testbench/commit_chk.sv
`timescale 1ns/100ps

module commit_chk
  import core_pkg::*;
(
  input logic                  clk,
  input logic                  i_reset,
  input logic                  i_valid,
  input logic                  i_commit_valid,
  input logic                  i_commit_wen,
  input logic [REG_ADDR_W-1:0] i_commit_rd,
  input logic [XLEN-1:0]       i_commit_rd_wdata,
  input logic [REG_ADDR_W-1:0] i_rs1_idx,
  input logic [XLEN-1:0]       i_rs1_data
);

  int failures = 0;

  // trace valid is the strobe delayed by one cycle
  assert property (@(posedge clk) disable iff (i_reset) i_valid |=> i_commit_valid)
    else begin
      $error("strobe not followed by a commit trace");
      failures++;
    end

  assert property (@(posedge clk) disable iff (i_reset) !i_valid |=> !i_commit_valid)
    else begin
      $error("commit trace without a strobe");
      failures++;
    end

  assert property (@(posedge clk) i_reset |=> !i_commit_valid)
    else begin
      $error("commit trace valid right after reset");
      failures++;
    end

  // traced write shows on the read port except at x0
  assert property (@(posedge clk) disable iff (i_reset)
      (i_commit_wen && i_rs1_idx == i_commit_rd) |->
      i_rs1_data == ((i_commit_rd == '0) ? '0 : i_commit_rd_wdata))
    else begin
      $error("traced register write does not match the read port");
      failures++;
    end

endmodule

bind commit_top commit_chk chk_i (
  .clk               (clk),
  .i_reset           (i_reset),
  .i_valid           (i_valid),
  .i_commit_valid    (o_commit_valid),
  .i_commit_wen      (o_commit_wen),
  .i_commit_rd       (o_commit_rd),
  .i_commit_rd_wdata (o_commit_rd_wdata),
  .i_rs1_idx         (i_rs1_idx),
  .i_rs1_data        (rs1_data)
);

//--- testbench/commit_tests.txt
# name wen brch jal jalr csr ecall mret rd rs1 csr_addr imm res next_pc rd_data
# all numbers hex, one instruction per line in program order
alu_x1      1 0 0 0 0 0 0 01 00 000 00000000 00000010 80000004 00000010
alu_x2      1 0 0 0 0 0 0 02 00 000 00000000 00000100 80000008 00000100
alu_x0      1 0 0 0 0 0 0 00 00 000 00000000 deadbeef 8000000c deadbeef
jalr_x0     1 0 0 1 0 0 0 03 00 000 80000100 00000000 80000100 80000010
br_taken    0 1 0 0 0 0 0 00 00 000 00000020 00000001 80000120 00000000
br_not      0 1 0 0 0 0 0 00 00 000 00000040 00000000 80000124 00000000
jal_x4      1 0 1 0 0 0 0 04 00 000 000000dc 00000000 80000200 80000128
alu_x5      1 0 0 0 0 0 0 05 00 000 00000000 80000300 80000204 80000300
jalr_x5     1 0 0 1 0 0 0 06 05 000 00000008 00000000 80000308 80000208
csr_mtvec_w 1 0 0 0 1 0 0 07 00 305 00000000 80000400 8000030c 00000000
csr_mtvec_r 1 0 0 0 1 0 0 08 00 305 00000000 80000400 80000310 80000400
ecall       0 0 0 0 0 1 0 00 00 000 00000000 00000000 80000400 00000000
csr_mepc    1 0 0 0 1 0 0 09 00 341 00000000 80000310 80000404 80000310
csr_mcause  1 0 0 0 1 0 0 0a 00 342 00000000 0000000b 80000408 0000000b
mret        0 0 0 0 0 0 1 00 00 000 00000000 00000000 80000310 00000000
alu_x11     1 0 0 0 0 0 0 0b 00 000 00000000 12345678 80000314 12345678
jalr_x3     0 0 0 1 0 0 0 00 03 000 00000004 00000000 80000014 00000000

//--- testbench/tb_top.sv
`timescale 1ns/100ps

module tb_top
  import core_pkg::*;
();

  // one instruction as the execute stage hands it over
  typedef struct packed {
    logic [6:0]            flags;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       res;
  } strobe_t;

  logic                  clk;
  logic                  i_reset;
  logic                  i_valid;
  logic                  i_wen;
  logic                  i_brch;
  logic                  i_jal;
  logic                  i_jalr;
  logic                  i_csr;
  logic                  i_ecall;
  logic                  i_mret;
  logic [REG_ADDR_W-1:0] i_rd;
  logic [REG_ADDR_W-1:0] i_rs1_idx;
  logic [CSR_ADDR_W-1:0] i_csr_addr;
  logic [XLEN-1:0]       i_imm;
  logic [XLEN-1:0]       i_res;
  logic                  o_commit_valid;
  logic [XLEN-1:0]       o_commit_pc;
  logic [XLEN-1:0]       o_commit_next_pc;
  logic [REG_ADDR_W-1:0] o_commit_rd;
  logic                  o_commit_wen;
  logic [XLEN-1:0]       o_commit_rd_wdata;

  strobe_t tests[$];
  int      num_tests = 0;
  int      errors;
  int      checked;
  int      gap;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  commit_top dut_i (.*);

  commit_checker checker_i (
    .clk               (clk),
    .i_reset           (i_reset),
    .i_commit_valid    (o_commit_valid),
    .i_commit_pc       (o_commit_pc),
    .i_commit_next_pc  (o_commit_next_pc),
    .i_commit_rd       (o_commit_rd),
    .i_commit_wen      (o_commit_wen),
    .i_commit_rd_wdata (o_commit_rd_wdata),
    .o_errors          (errors),
    .o_checked         (checked)
  );

  task automatic drive_strobe(strobe_t s);
    i_valid = 1'b1;
    {i_wen, i_brch, i_jal, i_jalr, i_csr, i_ecall, i_mret} = s.flags;
    i_rd       = s.rd;
    i_rs1_idx  = s.rs1;
    i_csr_addr = s.csr_addr;
    i_imm      = s.imm;
    i_res      = s.res;
  endtask

  // all fields zero so rs1 reads x0 between strobes
  task automatic drive_idle();
    drive_strobe('0);
    i_valid = 1'b0;
  endtask

  task automatic load_tests();
    int           fd;
    string        line;
    logic [127:0] name;
    logic [31:0]  v [14];
    strobe_t      s;
    fd = $fopen("testbench/commit_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/commit_tests.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                    v[10], v[11], v[12], v[13]) == 15) begin
          s.flags    = {v[0][0], v[1][0], v[2][0], v[3][0], v[4][0], v[5][0], v[6][0]};
          s.rd       = v[7][REG_ADDR_W-1:0];
          s.rs1      = v[8][REG_ADDR_W-1:0];
          s.csr_addr = v[9][CSR_ADDR_W-1:0];
          s.imm      = v[10];
          s.res      = v[11];
          tests.push_back(s);
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    void'($urandom(44417));
    i_reset = 1'b1;
    drive_idle();
    load_tests();
    num_tests = tests.size();
    repeat (4) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;
    if (num_tests == 0) begin
      $display("no tests were loaded from the stimulus file");
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      foreach (tests[i]) begin
        // idle gap of 0 to 2 cycles, zero gives back to back commits
        gap = $urandom_range(2, 0);
        repeat (gap) begin
          drive_idle();
          @(negedge clk);
        end
        drive_strobe(tests[i]);
        @(negedge clk);
      end
      drive_idle();
      wait (checked >= num_tests);
      repeat (2) @(negedge clk);
      $display("checked %0d of %0d commits, %0d errors, %0d assertion failures",
               checked, num_tests, errors, dut_i.chk_i.failures);
      if (errors == 0 && dut_i.chk_i.failures == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

  // worst case is three cycles per line plus reset and trace delay
  initial begin
    wait (num_tests > 0);
    repeat (num_tests * 4 + 20) @(posedge clk);
    $display("watchdog expired, %0d expected commits still pending", num_tests - checked);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
